// File: Bender.yml
package:
  name: velocity_cache_array

sources:
  # Design
  - include_dirs:
      - hw
    files:
      - hw/md_pkg.sv
      - hw/cell_ram.sv
      - hw/velocity_cache.sv
      - hw/mu_ctrl_regs.sv
      - hw/velocity_cache_array.sv
  # Verification
  - target: test
    include_dirs:
      - hw
    files:
      - verification/velocity_cache_props.sv
      - verification/tb_velocity_cache_array.sv

// File: hw/cell_ram.sv
// Single-port velocity RAM for one cache buffer
// Registered address and registered read data, 2 cycle read latency
// Array starts out all zero
`timescale 1ns/10ps
`include "md_defs.svh"

module cell_ram #(
	parameter int DEPTH = `MD_DEPTH
) (
	input  logic                      clk,
	input  logic [`MD_ADDR_WIDTH-1:0] addr,
	input  md_pkg::velocity_t         wdata,
	input  logic                      wren,
	input  logic                      rden,
	output md_pkg::velocity_t         rdata
);

	import md_pkg::*;

	// Storage array
	velocity_t mem [DEPTH];

	// First read stage
	logic [`MD_ADDR_WIDTH-1:0] addr_q;
	logic                      rden_q;

	// No init file, so both buffers come up empty
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			mem[i] = '0;
		end
	end

	// Write lands on the edge that samples wren
	always_ff @(posedge clk)
	begin
		if (wren)
		begin
			mem[addr] <= wdata;
		end
	end

	// Read pipeline
	// Address registered first, array output registered on the next edge
	always_ff @(posedge clk)
	begin
		addr_q <= addr;
		rden_q <= rden;
		// Output holds when nobody reads
		if (rden_q)
		begin
			rdata <= mem[addr_q];
		end
	end

endmodule

// File: hw/md_defs.svh
// Shared sizing macros for the velocity cache array
// Data width of one velocity component, cache address width and depth
// Cell coordinate width and the number of cells along x
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// One velocity component, the full record is three of these
`define MD_DATA_WIDTH 32

// Cache address, wide enough for MD_DEPTH words
`define MD_ADDR_WIDTH 8

// Words per buffer
// Address 0 is the particle count, records start at 1
`define MD_DEPTH 220

// Width of a single cell coordinate
`define MD_CELL_ID_WIDTH 4

// Cells along x, y and z are fixed at 1
`define MD_NUM_CELLS 4

`endif

// File: hw/md_pkg.sv
// Shared types for the velocity cache array
// Velocity record, cell id, motion update broadcast word
// Cache update FSM states
`include "md_defs.svh"

package md_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data records
	////////////////////////////////////////////////////////////////////////////

	// Velocity record, vz at the top and vx at the bottom
	typedef struct packed {
		logic [`MD_DATA_WIDTH-1:0] vz;
		logic [`MD_DATA_WIDTH-1:0] vy;
		logic [`MD_DATA_WIDTH-1:0] vx;
	} velocity_t;

	// Cell coordinate, x at the top
	typedef struct packed {
		logic [`MD_CELL_ID_WIDTH-1:0] cell_x;
		logic [`MD_CELL_ID_WIDTH-1:0] cell_y;
		logic [`MD_CELL_ID_WIDTH-1:0] cell_z;
	} cell_id_t;

	// Broadcast word from the motion update unit
	// Every cell sees the same word and filters on dst
	typedef struct packed {
		logic      valid;
		cell_id_t  dst;
		velocity_t data;
	} mu_bcast_t;

	////////////////////////////////////////////////////////////////////////////
	// Cache control
	////////////////////////////////////////////////////////////////////////////

	// Per-cell update sequence
	typedef enum logic [1:0] {
		wait_start  = 2'b00,
		update      = 2'b01,
		write_count = 2'b10,
		swap        = 2'b11
	} cache_state_e;

endpackage

// File: hw/mu_ctrl_regs.sv
// Motion update control and status registers
// Address 0 control, bit 0 is the motion update enable
// Address 1 count of completed updates, read only
`timescale 1ns/10ps

module mu_ctrl_regs #(
	parameter int REG_WIDTH = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 reg_wr,
	input  logic                 reg_rd,
	input  logic                 reg_addr,
	input  logic [REG_WIDTH-1:0] reg_wdata,
	output logic [REG_WIDTH-1:0] reg_rdata,
	// One cycle pulse per finished update
	input  logic                 swap_done,
	output logic                 mu_enable
);

	// Register map
	localparam logic CTRL_ADDR  = 1'b0;
	localparam logic COUNT_ADDR = 1'b1;

	// Completed updates, wraps
	logic [REG_WIDTH-1:0] update_cnt;

	// Control bit
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mu_enable <= 1'b0;
		end
		else if (reg_wr && (reg_addr == CTRL_ADDR))
		begin
			mu_enable <= reg_wdata[0];
		end
	end

	// Update counter, writes to it are ignored
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			update_cnt <= '0;
		end
		else if (swap_done)
		begin
			update_cnt <= update_cnt + 1'b1;
		end
	end

	// Registered readback, one cycle after reg_rd
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			reg_rdata <= '0;
		end
		else if (reg_rd)
		begin
			reg_rdata <= (reg_addr == COUNT_ADDR) ? update_cnt
				: {{(REG_WIDTH-1){1'b0}}, mu_enable};
		end
	end

endmodule

// File: hw/velocity_cache.sv
// Double-buffered velocity cache for one spatial cell
// Update FSM that captures broadcast records for this cell
// Particle count write to address 0 and the buffer swap
// Two cell_ram buffers, one read side and one shadow side
`timescale 1ns/10ps
`include "md_defs.svh"

module velocity_cache #(
	parameter md_pkg::cell_id_t CELL_ID = '{4'd1, 4'd1, 4'd1}
) (
	input  logic                      clk,
	input  logic                      rst,
	// Held high for the whole motion update
	input  logic                      mu_enable,
	input  md_pkg::mu_bcast_t         bcast,
	input  logic                      rden,
	input  logic [`MD_ADDR_WIDTH-1:0] rd_addr,
	output md_pkg::velocity_t         rd_data,
	output logic                      swap_done
);

	import md_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Update control
	////////////////////////////////////////////////////////////////////////////

	cache_state_e state;

	// Buffer holding the readable set, the other one is the shadow
	logic active;

	// Next free address in the shadow, starts at 1 to keep address 0 free
	logic [`MD_ADDR_WIDTH-1:0] new_cnt;

	// Registered shadow write port
	logic                      wr_en;
	logic [`MD_ADDR_WIDTH-1:0] wr_addr;
	velocity_t                 wr_data;

	// Record is for this cell and the FSM is collecting
	logic dst_match;
	logic accept;

	// Count word for address 0, count in the low bits of vx
	velocity_t count_word;

	assign dst_match = bcast.valid && (bcast.dst == CELL_ID);

	// First record may arrive in the same cycle as the enable
	// Records are still taken in the cycle that sees the enable drop
	assign accept = dst_match
		&& (((state == wait_start) && mu_enable) || (state == update));

	always_comb
	begin
		count_word    = '0;
		// Counter is one past the number of records taken
		count_word.vx = `MD_DATA_WIDTH'(new_cnt - 1'b1);
	end

	// Control state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= wait_start;
			active  <= 1'b0;
			new_cnt <= `MD_ADDR_WIDTH'(1);
			wr_en   <= 1'b0;
		end
		else
		begin
			// One write per accepted record, one more for the count
			wr_en <= accept || (state == write_count);
			if (accept)
			begin
				new_cnt <= new_cnt + 1'b1;
			end

			case (state)
				wait_start:
				begin
					if (mu_enable)
					begin
						state <= update;
					end
				end
				update:
				begin
					// Enable low ends collection
					if (!mu_enable)
					begin
						state <= write_count;
					end
				end
				write_count:
				begin
					state <= swap;
				end
				swap:
				begin
					// Shadow becomes readable at the end of this cycle
					active  <= ~active;
					new_cnt <= `MD_ADDR_WIDTH'(1);
					state   <= wait_start;
				end
				default:
				begin
					state <= wait_start;
				end
			endcase
		end
	end

	// Shadow write address and data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_addr <= new_cnt;
			wr_data <= bcast.data;
		end
		else if (state == write_count)
		begin
			wr_addr <= '0;
			wr_data <= count_word;
		end
	end

	// Pulse for the update counter, high during swap only
	assign swap_done = (state == swap);

	////////////////////////////////////////////////////////////////////////////
	// Buffer steering
	////////////////////////////////////////////////////////////////////////////

	logic [`MD_ADDR_WIDTH-1:0] buf0_addr;
	logic [`MD_ADDR_WIDTH-1:0] buf1_addr;
	velocity_t                 buf0_rdata;
	velocity_t                 buf1_rdata;

	// active low: buf0 reads, buf1 takes writes
	assign buf0_addr = active ? wr_addr : rd_addr;
	assign buf1_addr = active ? rd_addr : wr_addr;

	cell_ram #(
		.DEPTH(`MD_DEPTH)
	) buf0 (
		.clk  (clk),
		.addr (buf0_addr),
		.wdata(wr_data),
		.wren (wr_en && active),
		.rden (rden && !active),
		.rdata(buf0_rdata)
	);

	cell_ram #(
		.DEPTH(`MD_DEPTH)
	) buf1 (
		.clk  (clk),
		.addr (buf1_addr),
		.wdata(wr_data),
		.wren (wr_en && !active),
		.rden (rden && active),
		.rdata(buf1_rdata)
	);

	// Output side follows the active bit
	assign rd_data = active ? buf1_rdata : buf0_rdata;

endmodule

// File: hw/velocity_cache_array.sv
// Top level of the velocity storage
// One velocity cache per cell along x, ids (1,1,1) to (4,1,1)
// Control register block, read decode and delayed read data select
`timescale 1ns/10ps
`include "md_defs.svh"

module velocity_cache_array (
	input  logic                      clk,
	input  logic                      rst,
	// Motion update broadcast, shared by all cells
	input  md_pkg::mu_bcast_t         bcast,
	// Read port
	input  logic                      rden,
	input  md_pkg::cell_id_t          rd_cell,
	input  logic [`MD_ADDR_WIDTH-1:0] rd_addr,
	output md_pkg::velocity_t         rd_data,
	// Register port
	input  logic                      reg_wr,
	input  logic                      reg_rd,
	input  logic                      reg_addr,
	input  logic [31:0]               reg_wdata,
	output logic [31:0]               reg_rdata
);

	import md_pkg::*;

	localparam int NUM_CELLS = `MD_NUM_CELLS;

	logic                 mu_enable;
	logic [NUM_CELLS-1:0] swap_done;

	// One-hot cell select and gated read enables
	logic [NUM_CELLS-1:0] cell_sel;
	logic [NUM_CELLS-1:0] cell_rden;
	velocity_t            cell_rd_data [NUM_CELLS];

	// Select delayed to line up with the 2 cycle RAM read
	logic [NUM_CELLS-1:0] sel_q1;
	logic [NUM_CELLS-1:0] sel_q2;

	////////////////////////////////////////////////////////////////////////////
	// Cell caches
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_CELLS; g++)
	begin : g_cell
		// x runs from 1, y and z fixed at 1
		localparam cell_id_t ID = '{
			cell_x: `MD_CELL_ID_WIDTH'(g + 1),
			cell_y: `MD_CELL_ID_WIDTH'(1),
			cell_z: `MD_CELL_ID_WIDTH'(1)
		};

		assign cell_sel[g]  = (rd_cell == ID);
		assign cell_rden[g] = rden && cell_sel[g];

		velocity_cache #(
			.CELL_ID(ID)
		) u_cache (
			.clk      (clk),
			.rst      (rst),
			.mu_enable(mu_enable),
			.bcast    (bcast),
			.rden     (cell_rden[g]),
			.rd_addr  (rd_addr),
			.rd_data  (cell_rd_data[g]),
			.swap_done(swap_done[g])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////////////////////

	// All caches swap together, cell 0 stands for the rest
	mu_ctrl_regs #(
		.REG_WIDTH(32)
	) u_regs (
		.clk      (clk),
		.rst      (rst),
		.reg_wr   (reg_wr),
		.reg_rd   (reg_rd),
		.reg_addr (reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.swap_done(swap_done[0]),
		.mu_enable(mu_enable)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read data select
	////////////////////////////////////////////////////////////////////////////

	// Reads to a cell outside the grid select nothing
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sel_q1 <= '0;
			sel_q2 <= '0;
		end
		else
		begin
			sel_q1 <= cell_rden;
			sel_q2 <= sel_q1;
		end
	end

	// Zero when no read is due this cycle
	always_comb
	begin
		rd_data = '0;
		for (int i = 0; i < NUM_CELLS; i++)
		begin
			if (sel_q2[i])
			begin
				rd_data = cell_rd_data[i];
			end
		end
	end

endmodule

// File: velocity_cache_array.f
+incdir+hw
hw/md_pkg.sv
hw/cell_ram.sv
hw/velocity_cache.sv
hw/mu_ctrl_regs.sv
hw/velocity_cache_array.sv
verification/velocity_cache_props.sv
verification/tb_velocity_cache_array.sv

// File: verification/tb_velocity_cache_array.sv
// Testbench for the velocity cache array
// Clock, reset, register and broadcast stimulus
// Per-cell model of the last finished update, read checks against it
// Bound FSM properties on every cache, per-test report, cycle limit
`timescale 1ns/10ps
`include "md_defs.svh"

module tb_velocity_cache_array;

	import md_pkg::*;

	localparam int NUM_CELLS = `MD_NUM_CELLS;
	// Tests take about 350 cycles
	localparam int CYCLE_LIMIT = 4000;

	logic                      clk;
	logic                      rst;
	mu_bcast_t                 bcast;
	logic                      rden;
	cell_id_t                  rd_cell;
	logic [`MD_ADDR_WIDTH-1:0] rd_addr;
	velocity_t                 rd_data;
	logic                      reg_wr;
	logic                      reg_rd;
	logic                      reg_addr;
	logic [31:0]               reg_wdata;
	logic [31:0]               reg_rdata;

	// Model of the readable set and of the set being collected
	velocity_t done_mem [NUM_CELLS][`MD_DEPTH];
	int        done_n   [NUM_CELLS];
	velocity_t new_mem  [NUM_CELLS][`MD_DEPTH];
	int        new_n    [NUM_CELLS];

	integer seed;
	int     pass_cnt;
	int     fail_cnt;
	int     cycles;
	int     updates;

	velocity_cache_array dut (
		.clk      (clk),
		.rst      (rst),
		.bcast    (bcast),
		.rden     (rden),
		.rd_cell  (rd_cell),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.reg_wr   (reg_wr),
		.reg_rd   (reg_rd),
		.reg_addr (reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata)
	);

	bind velocity_cache velocity_cache_props props (
		.clk      (clk),
		.rst      (rst),
		.mu_enable(mu_enable),
		.state    (state),
		.wr_en    (wr_en),
		.swap_done(swap_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Clock and cycle limit
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: no result after %0d cycles, run stopped", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Cell index 0 sits at x = 1
	function automatic cell_id_t cell_id(input int c);
		cell_id_t id;
		id.cell_x = `MD_CELL_ID_WIDTH'(c + 1);
		id.cell_y = `MD_CELL_ID_WIDTH'(1);
		id.cell_z = `MD_CELL_ID_WIDTH'(1);
		return id;
	endfunction

	// Particle count lives in the low bits of word 0
	function automatic velocity_t count_word(input int n);
		return {64'd0, 32'(n)};
	endfunction

	function automatic velocity_t random_velocity();
		return {$random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic check_value(input logic [95:0] got, input logic [95:0] exp,
		input string what);
		assert (got === exp)
			pass_cnt++;
		else
		begin
			fail_cnt++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic test_done(input string name, input int fails_before);
		if (fail_cnt == fails_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d mismatches", name, fail_cnt - fails_before);
	endtask

	task automatic reg_write(input logic addr, input logic [31:0] data);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(posedge clk);
		#1;
		reg_wr = 1'b0;
	endtask

	// Read data is registered and ready one edge later
	task automatic reg_read(input logic addr, output logic [31:0] data);
		reg_rd   = 1'b1;
		reg_addr = addr;
		@(posedge clk);
		#1;
		reg_rd = 1'b0;
		data   = reg_rdata;
	endtask

	// rd_data valid after the second edge from the one sampling rden
	task automatic read_check(input int c, input int addr, input velocity_t exp);
		rden    = 1'b1;
		rd_cell = cell_id(c);
		rd_addr = `MD_ADDR_WIDTH'(addr);
		@(posedge clk);
		#1;
		rden = 1'b0;
		@(posedge clk);
		#1;
		check_value(rd_data, exp, $sformatf("cell %0d addr %0d", c + 1, addr));
	endtask

	// Count word and every record of every cell
	task automatic check_cells();
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			read_check(c, 0, count_word(done_n[c]));
			for (int a = 1; a <= done_n[c]; a++)
			begin
				read_check(c, a, done_mem[c][a]);
			end
		end
	endtask

	// Sends n valid records with idle cycles mixed in
	// Some go off the grid when with_bad is set
	task automatic send_records(input int n, input bit with_bad);
		int c;
		int sent;
		int kind;
		sent = 0;
		while (sent < n)
		begin
			c          = $unsigned($random(seed)) % NUM_CELLS;
			bcast.dst  = cell_id(c);
			bcast.data = random_velocity();
			// About one cycle in four carries valid low and real looking data
			if ($unsigned($random(seed)) % 4 == 0)
			begin
				bcast.valid = 1'b0;
			end
			else
			begin
				bcast.valid = 1'b1;
				sent++;
				if (with_bad && ($unsigned($random(seed)) % 3 == 0))
				begin
					kind = $unsigned($random(seed)) % 3;
					// x before the first cell, past the last, or y off the row
					if (kind == 0)
						bcast.dst.cell_x = '0;
					else if (kind == 1)
						bcast.dst.cell_x = `MD_CELL_ID_WIDTH'(NUM_CELLS + 1);
					else
						bcast.dst.cell_y = `MD_CELL_ID_WIDTH'(2);
				end
				else
				begin
					new_n[c]++;
					new_mem[c][new_n[c]] = bcast.data;
				end
			end
			@(posedge clk);
			#1;
		end
		bcast.valid = 1'b0;
	endtask

	// Drop the enable and wait for the swap through the count register
	task automatic finish_update();
		logic [31:0] cnt;
		int          tries;
		bcast.valid = 1'b0;
		reg_write(1'b0, 32'd0);
		updates++;
		tries = 0;
		reg_read(1'b1, cnt);
		while ((cnt != updates) && (tries < 20))
		begin
			reg_read(1'b1, cnt);
			tries++;
		end
		check_value(cnt, updates, "update count");
		// New set becomes the readable one
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			done_n[c] = new_n[c];
			for (int a = 1; a <= new_n[c]; a++)
			begin
				done_mem[c][a] = new_mem[c][a];
			end
			new_n[c] = 0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rv;
		int          mark;
		int          props_fails;
		seed      = 32'h92d2a3b7;
		pass_cnt  = 0;
		fail_cnt  = 0;
		cycles    = 0;
		updates   = 0;
		rst       = 1'b1;
		bcast     = '0;
		rden      = 1'b0;
		rd_cell   = '0;
		rd_addr   = '0;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		reg_addr  = 1'b0;
		reg_wdata = '0;
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			done_n[c] = 0;
			new_n[c]  = 0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// Empty buffers and a zero count
		mark = fail_cnt;
		for (int c = 0; c < NUM_CELLS; c++)
		begin
			read_check(c, 0, '0);
			read_check(c, 1, '0);
			read_check(c, 2 + $unsigned($random(seed)) % (`MD_DEPTH - 3), '0);
			read_check(c, `MD_DEPTH - 1, '0);
		end
		reg_read(1'b1, rv);
		check_value(rv, 0, "update count after reset");
		test_done("1 reset contents", mark);

		mark = fail_cnt;
		reg_write(1'b0, 32'd1);
		send_records(20, 1'b0);
		finish_update();
		check_cells();
		test_done("2 first update", mark);

		mark = fail_cnt;
		reg_write(1'b0, 32'd1);
		send_records(20, 1'b1);
		finish_update();
		check_cells();
		test_done("3 filtered records", mark);

		// Mid-update reads must still see the previous set
		mark = fail_cnt;
		reg_write(1'b0, 32'd1);
		send_records(10, 1'b0);
		check_cells();
		send_records(10, 1'b0);
		finish_update();
		check_cells();
		test_done("4 reads across an update", mark);

		// Enable readback and an empty update
		mark = fail_cnt;
		reg_read(1'b0, rv);
		check_value(rv, 0, "control register idle");
		reg_write(1'b0, 32'd1);
		reg_read(1'b0, rv);
		check_value(rv, 1, "control register enabled");
		finish_update();
		reg_read(1'b0, rv);
		check_value(rv, 0, "control register cleared");
		check_cells();
		test_done("5 registers", mark);

		props_fails = dut.g_cell[0].u_cache.props.fail_cnt
			+ dut.g_cell[1].u_cache.props.fail_cnt
			+ dut.g_cell[2].u_cache.props.fail_cnt
			+ dut.g_cell[3].u_cache.props.fail_cnt;
		if (props_fails != 0)
		begin
			$display("Bound FSM properties fired %0d times", props_fails);
			fail_cnt += props_fails;
		end
		$display("totals: %0d checks ok, %0d checks wrong", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: verification/velocity_cache_props.sv
// Concurrent checks on the velocity cache update FSM
// Count write after the enable drop, one-cycle swap pulse,
// no shadow write while idle, FSM state after reset
`timescale 1ns/10ps

module velocity_cache_props (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 mu_enable,
	input  md_pkg::cache_state_e state,
	input  logic                 wr_en,
	input  logic                 swap_done
);

	import md_pkg::*;

	// Fired assertions, collected by the testbench at the end
	int unsigned fail_cnt;

	initial
	begin
		fail_cnt = 0;
	end

	// Enable low in update always leads to the count write
	count_follows_update: assert property (@(posedge clk) disable iff (rst)
		((state == update) && !mu_enable) |=> (state == write_count))
	else
	begin
		fail_cnt++;
		$error("write_count did not follow a low enable in update");
	end

	// Swap pulse comes right after write_count and lasts one cycle
	swap_pulse_shape: assert property (@(posedge clk) disable iff (rst)
		swap_done |-> ($past(state) == write_count) ##1 !swap_done)
	else
	begin
		fail_cnt++;
		$error("swap_done was not a single cycle after write_count");
	end

	// Idle cache with no enable never writes its shadow
	no_idle_write: assert property (@(posedge clk) disable iff (rst)
		!(wr_en && (state == wait_start) && !mu_enable))
	else
	begin
		fail_cnt++;
		$error("shadow write enable high in wait_start with enable low");
	end

	// Reset puts the FSM back to wait_start
	reset_state: assert property (@(posedge clk)
		rst |=> (state == wait_start))
	else
	begin
		fail_cnt++;
		$error("FSM not in wait_start in the cycle after reset");
	end

endmodule
